/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_fetch_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
source/la_isa_pkg.sv
source/fetch_pkg.sv
source/fetch_unit.sv
source/fetch_queue.sv
source/pre_decoder.sv
source/fetch_top.sv
dv/fetch_props.sv
dv/tb_fetch_top.sv

/* dv/fetch_props.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_props (
    input wire logic                        clk,
    input wire logic                        rstn,
    input wire logic                        wb_cyc,
    input wire logic                        wb_stb,
    input wire logic                        wb_ack,
    input wire logic [fetch_pkg::ADR_W-1:0] wb_adr,
    input wire logic                        ibar_signal
);
    import fetch_pkg::*;

    // Strobe only inside a bus cycle
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rstn)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high outside a bus cycle");

    // Address held until the slave acknowledges
    a_adr_stable: assert property (@(posedge clk) disable iff (!rstn)
        (wb_stb && !wb_ack) |=> $stable(wb_adr))
        else $error("wb_adr changed before wb_ack");

    // Barrier is a single-cycle pulse
    a_ibar_pulse: assert property (@(posedge clk) disable iff (!rstn)
        ibar_signal |=> !ibar_signal)
        else $error("ibar_signal high for two cycles");

endmodule

bind fetch_top fetch_props u_fetch_props (.*);

`default_nettype wire

/* dv/tb_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;
    import fetch_pkg::*;
    import la_isa_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;
    localparam logic [XLEN-1:0] NOP      = 32'h0340_0000;
    localparam logic [XLEN-1:0] IBAR     = 32'h3872_8000;
    // 8 + 22 + 6 + 2 + 16 pairs over all tests
    localparam int TOTAL_PAIRS = 54;
    localparam int CYCLE_LIMIT = TOTAL_PAIRS * 8 * 3;

    logic clk;
    logic rstn;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [ADR_W-1:0] wb_adr;
    logic wb_ack;
    logic [XLEN-1:0] wb_dat_r;
    logic redirect_valid;
    logic [XLEN-1:0] redirect_pc;
    logic pair_valid;
    logic pair_ready;
    logic [XLEN-1:0] pair_inst0;
    logic [XLEN-1:0] pair_inst1;
    logic [XLEN-1:0] pair_pc;
    branch_type_e pair_btype;
    logic pair_bpos;
    logic ibar_signal;
    logic [XLEN-1:0] ibar_pc;
    logic ibar_pos;

    logic [XLEN-1:0] prog [logic [ADR_W-1:0]];
    logic [31:0] lfsr = 32'h5d0b;
    int errors = 0;
    int test_errors = 0;
    int tests_failed = 0;
    int tests_run = 0;
    int cycles = 0;
    logic saw_full = 1'b0;

    // Observed decode transfers and barrier pulses
    logic [XLEN-1:0] got_pc [$];
    logic [XLEN-1:0] got_i0 [$];
    logic [XLEN-1:0] got_i1 [$];
    branch_type_e got_bt [$];
    logic got_bp [$];
    logic [XLEN-1:0] pulse_pc [$];
    logic pulse_pos [$];

    fetch_top #(
        .QUEUE_DEPTH (4),
        .RESET_PC    (RESET_PC)
    ) UUT (.*);

    // ------------------------------------------------------------------------
    // Clock, reset and watchdog
    // ------------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("error: timeout after %0d cycles, tests did not finish", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Random source and program memory
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Unwritten words fold the whole word address, opcode stays zero
    function automatic logic [XLEN-1:0] mem_read(input logic [ADR_W-1:0] a);
        if (prog.exists(a)) begin
            return prog[a];
        end
        return {6'd0, a[25:0] ^ {22'd0, a[29:26]}};
    endfunction

    task automatic put_word(input logic [XLEN-1:0] byte_addr, input logic [XLEN-1:0] data);
        prog[byte_addr[XLEN-1:2]] = data;
    endtask

    // Wishbone slave with 0 to 3 wait cycles per read
    initial begin
        int wait_left;
        logic busy;
        wb_ack = 1'b0;
        wb_dat_r = '0;
        busy = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            #1;
            if (wb_ack) begin
                wb_ack = 1'b0;
            end else if (rstn && wb_cyc && wb_stb) begin
                if (!busy) begin
                    busy = 1'b1;
                    draw_bits(2, wait_left);
                end
                if (wait_left == 0) begin
                    wb_ack = 1'b1;
                    wb_dat_r = mem_read(wb_adr);
                    busy = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // Sample late in the cycle, after inputs and registers settled
    initial begin
        forever begin
            @(posedge clk);
            #3;
            if (pair_valid && pair_ready) begin
                got_pc.push_back(pair_pc);
                got_i0.push_back(pair_inst0);
                got_i1.push_back(pair_inst1);
                got_bt.push_back(pair_btype);
                got_bp.push_back(pair_bpos);
            end
            if (ibar_signal) begin
                pulse_pc.push_back(ibar_pc);
                pulse_pos.push_back(ibar_pos);
            end
            if (rstn && UUT.queue_full) begin
                saw_full = 1'b1;
            end
            if (rstn) begin
                check_bit("wb_we", wb_we, 1'b0);
            end
            if (rstn && UUT.queue_full && wb_cyc) begin
                $display("error: bus cycle active while the fetch queue is full at %0t", $time);
                errors++;
                test_errors++;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Expected classification
    // ------------------------------------------------------------------------
    function automatic branch_type_e slot_type(input logic [XLEN-1:0] inst);
        logic [5:0] op;
        op = inst[31:26];
        if (op == OP_JIRL) begin
            return BR_INDIRECT;
        end
        if (op == OP_B || op == OP_BL) begin
            return BR_UNCOND;
        end
        if (op == OP_BEQZ || op == OP_BNEZ || (op >= OP_BEQ && op <= OP_BGEU)) begin
            return BR_PCREL;
        end
        return BR_NONE;
    endfunction

    function automatic branch_type_e expect_btype(input logic [XLEN-1:0] i0,
                                                  input logic [XLEN-1:0] i1,
                                                  input logic [XLEN-1:0] pc);
        if (slot_type(i1) != BR_NONE) begin
            return slot_type(i1);
        end
        return pc[2] ? BR_NONE : slot_type(i0);
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_word(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH @%0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_btype(input string what, input branch_type_e got,
                               input branch_type_e exp);
        if (got !== exp) begin
            $display("MISMATCH @%0t: %s got %s expected %s", $time, what, got.name(), exp.name());
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH @%0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_pair(input int idx, input logic [XLEN-1:0] pc);
        logic [XLEN-1:0] i0;
        logic [XLEN-1:0] i1;
        i0 = mem_read({pc[XLEN-1:3], 1'b0});
        i1 = mem_read({pc[XLEN-1:3], 1'b1});
        check_word("pair_pc", got_pc[idx], pc);
        check_word("pair_inst0", got_i0[idx], i0);
        check_word("pair_inst1", got_i1[idx], i1);
        check_btype("pair_btype", got_bt[idx], expect_btype(i0, i1, pc));
        check_bit("pair_bpos", got_bp[idx], slot_type(i1) != BR_NONE);
    endtask

    // ------------------------------------------------------------------------
    // Sequencing helpers
    // ------------------------------------------------------------------------
    task automatic wait_pairs(input int n);
        while (got_pc.size() < n) begin
            @(posedge clk);
        end
    endtask

    // Restart fetch with decode stalled, then drop stale observations
    task automatic start_at(input logic [XLEN-1:0] pc);
        @(posedge clk);
        #1;
        pair_ready = 1'b0;
        redirect_valid = 1'b1;
        redirect_pc = pc;
        @(posedge clk);
        #1;
        redirect_valid = 1'b0;
        got_pc.delete();
        got_i0.delete();
        got_i1.delete();
        got_bt.delete();
        got_bp.delete();
        pulse_pc.delete();
        pulse_pos.delete();
        pair_ready = 1'b1;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %s (%0d errors)", name, test_errors == 0 ? "ok" : "failed",
                 test_errors);
        test_errors = 0;
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_sequential();
        wait_pairs(8);
        for (int i = 0; i < 8; i++) begin
            check_pair(i, RESET_PC + 8 * i);
        end
        end_test("sequential");
    endtask

    task automatic test_classify();
        logic [XLEN-1:0] base;
        opcode_e ops [11];
        base = 32'h1c00_1000;
        ops = '{OP_BEQZ, OP_BNEZ, OP_JIRL, OP_B, OP_BL, OP_BEQ,
                OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
        for (int k = 0; k < 11; k++) begin
            put_word(base + 16 * k, {ops[k], 26'h0});
            put_word(base + 16 * k + 4, NOP);
            put_word(base + 16 * k + 8, NOP);
            put_word(base + 16 * k + 12, {ops[k], 26'h12});
        end
        start_at(base);
        wait_pairs(22);
        for (int i = 0; i < 22; i++) begin
            check_pair(i, base + 8 * i);
        end
        end_test("classify");
    endtask

    task automatic test_barrier();
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] exp_pc [6];
        base = 32'h1c00_2000;
        put_word(base, NOP);
        put_word(base + 4, NOP);
        put_word(base + 8, IBAR);
        put_word(base + 12, NOP);
        put_word(base + 16, NOP);
        put_word(base + 20, IBAR);
        // Restarts at base+8+4 and at base+16+4+4
        exp_pc = '{base, base + 8, base + 12, base + 16, base + 24, base + 32};
        start_at(base);
        wait_pairs(6);
        for (int i = 0; i < 6; i++) begin
            check_pair(i, exp_pc[i]);
        end
        if (pulse_pc.size() != 2) begin
            $display("error: expected 2 barrier pulses, saw %0d", pulse_pc.size());
            errors++;
            test_errors++;
        end else begin
            check_word("ibar_pc", pulse_pc[0], base + 8);
            check_bit("ibar_pos", pulse_pos[0], 1'b0);
            check_word("ibar_pc", pulse_pc[1], base + 16);
            check_bit("ibar_pos", pulse_pos[1], 1'b1);
        end
        end_test("barrier");
    endtask

    task automatic test_odd_redirect();
        logic [XLEN-1:0] base;
        base = 32'h1c00_3000;
        put_word(base, {OP_BEQ, 26'h40});
        put_word(base + 4, NOP);
        put_word(base + 8, {OP_BEQ, 26'h40});
        put_word(base + 12, NOP);
        start_at(base + 4);
        wait_pairs(2);
        check_pair(0, base + 4);
        check_btype("odd pc btype", got_bt[0], BR_NONE);
        check_pair(1, base + 8);
        end_test("odd_redirect");
    endtask

    task automatic test_backpressure();
        logic [XLEN-1:0] base;
        int stretch;
        base = 32'h1c00_4000;
        stretch = 0;
        start_at(base);
        saw_full = 1'b0;
        while (got_pc.size() < 16) begin
            @(posedge clk);
            #1;
            if (stretch == 0) begin
                pair_ready = ~pair_ready;
                draw_bits(pair_ready ? 3 : 4, stretch);
                // Stalls outlast four worst-case pair fetches so the queue fills
                stretch = stretch + (pair_ready ? 4 : 44);
            end else begin
                stretch--;
            end
        end
        pair_ready = 1'b1;
        for (int i = 0; i < 16; i++) begin
            check_pair(i, base + 8 * i);
        end
        if (!saw_full) begin
            $display("error: fetch queue never filled while decode was stalled");
            errors++;
            test_errors++;
        end
        end_test("backpressure");
    endtask

    initial begin
        rstn = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        pair_ready = 1'b1;
        for (int i = 0; i < 16; i++) begin
            put_word(RESET_PC + 4 * i, 32'h0280_0000 | i);
        end
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;

        test_sequential();
        test_classify();
        test_barrier();
        test_odd_redirect();
        test_backpressure();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // ------------------------------------------------------------------------
    // Datapath widths
    // ------------------------------------------------------------------------

    // PC and instruction width
    localparam int XLEN = 32;

    // Wishbone word address, byte address without bits 1..0
    localparam int ADR_W = XLEN - 2;

    // ------------------------------------------------------------------------
    // Fetch FSM
    // ------------------------------------------------------------------------
    // FS_IDLE   no bus cycle, waiting for queue space
    // FS_WORD0  reading the even word of the pair
    // FS_WORD1  reading the odd word of the pair
    typedef enum logic [1:0] {
        FS_IDLE  = 2'd0,
        FS_WORD0 = 2'd1,
        FS_WORD1 = 2'd2
    } fetch_state_e;

endpackage

`default_nettype wire

/* source/fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire logic                        clk,
    input  wire logic                        rstn,
    input  wire logic                        push_valid,
    input  wire logic [fetch_pkg::XLEN-1:0]  push_inst0,
    input  wire logic [fetch_pkg::XLEN-1:0]  push_inst1,
    input  wire logic [fetch_pkg::XLEN-1:0]  push_pc,
    output logic                             queue_full,
    input  wire logic                        pop,
    input  wire logic                        flush,
    output logic                             head_valid,
    output logic [fetch_pkg::XLEN-1:0]       head_inst0,
    output logic [fetch_pkg::XLEN-1:0]       head_inst1,
    output logic [fetch_pkg::XLEN-1:0]       head_pc
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    logic [XLEN-1:0]  mem_inst0 [QUEUE_DEPTH];
    logic [XLEN-1:0]  mem_inst1 [QUEUE_DEPTH];
    logic [XLEN-1:0]  mem_pc    [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    logic             do_push;
    logic             do_pop;

    assign queue_full = (count == (PTR_W+1)'(QUEUE_DEPTH));
    assign head_valid = (count != '0);

    assign do_push = push_valid && !queue_full && !flush;
    assign do_pop  = pop && head_valid && !flush;

    assign head_inst0 = mem_inst0[rd_ptr];
    assign head_inst1 = mem_inst1[rd_ptr];
    assign head_pc    = mem_pc[rd_ptr];

    // Storage, written on every accepted push
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_inst0[wr_ptr] <= push_inst0;
            mem_inst1[wr_ptr] <= push_inst1;
            mem_pc[wr_ptr]    <= push_pc;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, do_push} - {{PTR_W{1'b0}}, do_pop};
        end
    end

endmodule

`default_nettype wire

/* source/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int                         QUEUE_DEPTH = 4,
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC    = 32'h1c00_0000
) (
    input  wire logic                        clk,
    input  wire logic                        rstn,
    // Wishbone classic master
    output logic                             wb_cyc,
    output logic                             wb_stb,
    output logic                             wb_we,
    output logic [fetch_pkg::ADR_W-1:0]      wb_adr,
    input  wire logic                        wb_ack,
    input  wire logic [fetch_pkg::XLEN-1:0]  wb_dat_r,
    // Redirect from the back end
    input  wire logic                        redirect_valid,
    input  wire logic [fetch_pkg::XLEN-1:0]  redirect_pc,
    // Decode interface
    output logic                             pair_valid,
    input  wire logic                        pair_ready,
    output logic [fetch_pkg::XLEN-1:0]       pair_inst0,
    output logic [fetch_pkg::XLEN-1:0]       pair_inst1,
    output logic [fetch_pkg::XLEN-1:0]       pair_pc,
    output la_isa_pkg::branch_type_e         pair_btype,
    output logic                             pair_bpos,
    // Barrier
    output logic                             ibar_signal,
    output logic [fetch_pkg::XLEN-1:0]       ibar_pc,
    output logic                             ibar_pos
);
    import fetch_pkg::*;

    logic            push_valid;
    logic [XLEN-1:0] push_inst0;
    logic [XLEN-1:0] push_inst1;
    logic [XLEN-1:0] push_pc;
    logic            queue_full;

    logic            head_valid;
    logic [XLEN-1:0] head_inst0;
    logic [XLEN-1:0] head_inst1;
    logic [XLEN-1:0] head_pc;
    logic            pop;
    logic            flush;

    // Either restart source empties the queue in the same cycle
    assign flush = redirect_valid || ibar_signal;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch_unit (
        .clk            (clk),
        .rstn           (rstn),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_ack         (wb_ack),
        .wb_dat_r       (wb_dat_r),
        .push_valid     (push_valid),
        .push_inst0     (push_inst0),
        .push_inst1     (push_inst1),
        .push_pc        (push_pc),
        .queue_full     (queue_full),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .ibar_signal    (ibar_signal),
        .ibar_pc        (ibar_pc),
        .ibar_pos       (ibar_pos)
    );

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_fetch_queue (
        .clk        (clk),
        .rstn       (rstn),
        .push_valid (push_valid),
        .push_inst0 (push_inst0),
        .push_inst1 (push_inst1),
        .push_pc    (push_pc),
        .queue_full (queue_full),
        .pop        (pop),
        .flush      (flush),
        .head_valid (head_valid),
        .head_inst0 (head_inst0),
        .head_inst1 (head_inst1),
        .head_pc    (head_pc)
    );

    pre_decoder u_pre_decoder (
        .clk         (clk),
        .rstn        (rstn),
        .head_valid  (head_valid),
        .head_inst0  (head_inst0),
        .head_inst1  (head_inst1),
        .head_pc     (head_pc),
        .pop         (pop),
        .pair_valid  (pair_valid),
        .pair_ready  (pair_ready),
        .pair_inst0  (pair_inst0),
        .pair_inst1  (pair_inst1),
        .pair_pc     (pair_pc),
        .pair_btype  (pair_btype),
        .pair_bpos   (pair_bpos),
        .ibar_signal (ibar_signal),
        .ibar_pc     (ibar_pc),
        .ibar_pos    (ibar_pos)
    );

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = 32'h1c00_0000
) (
    input  wire logic                        clk,
    input  wire logic                        rstn,
    // Wishbone classic master
    output logic                             wb_cyc,
    output logic                             wb_stb,
    output logic                             wb_we,
    output logic [fetch_pkg::ADR_W-1:0]      wb_adr,
    input  wire logic                        wb_ack,
    input  wire logic [fetch_pkg::XLEN-1:0]  wb_dat_r,
    // Push into the fetch queue
    output logic                             push_valid,
    output logic [fetch_pkg::XLEN-1:0]       push_inst0,
    output logic [fetch_pkg::XLEN-1:0]       push_inst1,
    output logic [fetch_pkg::XLEN-1:0]       push_pc,
    input  wire logic                        queue_full,
    // Restart sources
    input  wire logic                        redirect_valid,
    input  wire logic [fetch_pkg::XLEN-1:0]  redirect_pc,
    input  wire logic                        ibar_signal,
    input  wire logic [fetch_pkg::XLEN-1:0]  ibar_pc,
    input  wire logic                        ibar_pos
);
    import fetch_pkg::*;

    fetch_state_e      state;
    logic [XLEN-1:0]   pc_q;
    logic [XLEN-1:0]   pend_pc;
    logic [XLEN-1:0]   inst0_q;
    logic              discard;

    logic              restart;
    logic [XLEN-1:0]   restart_pc;
    logic              drop_ack;

    // Redirect wins over a barrier in the same cycle
    assign restart    = redirect_valid || ibar_signal;
    assign restart_pc = redirect_valid ? redirect_pc :
                        ibar_pc + {{(XLEN-4){1'b0}}, ibar_pos, ~ibar_pos, 2'b00};

    // Read that finishes while a flush is pending or arriving
    assign drop_ack = wb_ack && (discard || restart);

    // ------------------------------------------------------------------------
    // Bus outputs
    // ------------------------------------------------------------------------
    assign wb_cyc = (state != FS_IDLE);
    assign wb_stb = (state != FS_IDLE);
    assign wb_we  = 1'b0;
    assign wb_adr = {pc_q[XLEN-1:3], state == FS_WORD1};

    // ------------------------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= FS_IDLE;
            pc_q       <= RESET_PC;
            discard    <= 1'b0;
            push_valid <= 1'b0;
        end else begin
            push_valid <= 1'b0;
            case (state)
                FS_IDLE: begin
                    // Queue is flushed by the restart, so no space check
                    if (restart) begin
                        pc_q  <= restart_pc;
                        state <= FS_WORD0;
                    end else if (!queue_full && !push_valid) begin
                        state <= FS_WORD0;
                    end
                end
                FS_WORD0, FS_WORD1: begin
                    if (drop_ack) begin
                        pc_q    <= restart ? restart_pc : pend_pc;
                        discard <= 1'b0;
                        state   <= FS_WORD0;
                    end else if (wb_ack && state == FS_WORD0) begin
                        inst0_q <= wb_dat_r;
                        state   <= FS_WORD1;
                    end else if (wb_ack) begin
                        push_valid <= 1'b1;
                        push_inst0 <= inst0_q;
                        push_inst1 <= wb_dat_r;
                        push_pc    <= pc_q;
                        pc_q       <= {pc_q[XLEN-1:3] + 1'b1, 3'b000};
                        state      <= FS_IDLE;
                    end else if (restart) begin
                        // Let the current read finish and throw it away
                        discard <= 1'b1;
                        pend_pc <= restart_pc;
                    end
                end
                default: state <= FS_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/la_isa_pkg.sv */
`default_nettype none

package la_isa_pkg;

    // ------------------------------------------------------------------------
    // Branch classification reported to decode
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        BR_NONE     = 2'b00,
        BR_UNCOND   = 2'b01,
        BR_PCREL    = 2'b10,
        BR_INDIRECT = 2'b11
    } branch_type_e;

    // ------------------------------------------------------------------------
    // Major opcodes in bits 31..26
    // ------------------------------------------------------------------------
    typedef enum logic [5:0] {
        OP_BEQZ = 6'b010000,
        OP_BNEZ = 6'b010001,
        OP_JIRL = 6'b010011,
        OP_B    = 6'b010100,
        OP_BL   = 6'b010101,
        OP_BEQ  = 6'b010110,
        OP_BNE  = 6'b010111,
        OP_BLT  = 6'b011000,
        OP_BGE  = 6'b011001,
        OP_BLTU = 6'b011010,
        OP_BGEU = 6'b011011
    } opcode_e;

    // ibar is 0x38728000 plus a 15-bit hint, so bits 31..15 are fixed
    localparam logic [16:0] IBAR_PREFIX = 17'h070E5;

endpackage

`default_nettype wire

/* source/pre_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module pre_decoder (
    input  wire logic                        clk,
    input  wire logic                        rstn,
    // Queue head
    input  wire logic                        head_valid,
    input  wire logic [fetch_pkg::XLEN-1:0]  head_inst0,
    input  wire logic [fetch_pkg::XLEN-1:0]  head_inst1,
    input  wire logic [fetch_pkg::XLEN-1:0]  head_pc,
    output logic                             pop,
    // Decode side
    output logic                             pair_valid,
    input  wire logic                        pair_ready,
    output logic [fetch_pkg::XLEN-1:0]       pair_inst0,
    output logic [fetch_pkg::XLEN-1:0]       pair_inst1,
    output logic [fetch_pkg::XLEN-1:0]       pair_pc,
    output la_isa_pkg::branch_type_e         pair_btype,
    output logic                             pair_bpos,
    // Barrier pulse
    output logic                             ibar_signal,
    output logic [fetch_pkg::XLEN-1:0]       ibar_pc,
    output logic                             ibar_pos
);
    import fetch_pkg::*;
    import la_isa_pkg::*;

    branch_type_e btype0;
    branch_type_e btype1;
    logic         ibar0;
    logic         ibar1;

    function automatic branch_type_e classify(input logic [XLEN-1:0] inst);
        opcode_e op;
        op = opcode_e'(inst[31:26]);
        case (op)
            OP_JIRL:          return BR_INDIRECT;
            OP_B, OP_BL:      return BR_UNCOND;
            OP_BEQZ, OP_BNEZ,
            OP_BEQ, OP_BNE,
            OP_BLT, OP_BGE,
            OP_BLTU, OP_BGEU: return BR_PCREL;
            default:          return BR_NONE;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Combinational classification of the head pair
    // ------------------------------------------------------------------------
    assign btype0 = classify(head_inst0);
    assign btype1 = classify(head_inst1);

    // Slot 0 is not a real instruction when the PC points at the odd word
    assign ibar0 = (head_inst0[31:15] == IBAR_PREFIX) && !head_pc[2];
    assign ibar1 = (head_inst1[31:15] == IBAR_PREFIX);

    assign pair_btype = (btype1 != BR_NONE) ? btype1 :
                        head_pc[2]          ? BR_NONE : btype0;
    assign pair_bpos  = (btype1 != BR_NONE);

    assign pair_inst0 = head_inst0;
    assign pair_inst1 = head_inst1;
    assign pair_pc    = head_pc;

    // Hold decode off during the pulse, the queue is being flushed
    assign pair_valid = head_valid && !ibar_signal;
    assign pop        = pair_valid && pair_ready;

    // ------------------------------------------------------------------------
    // Barrier capture
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ibar_signal <= 1'b0;
        end else begin
            ibar_signal <= pop && (ibar0 || ibar1);
        end
    end

    // First ibar in the pair wins
    always_ff @(posedge clk) begin
        if (pop && (ibar0 || ibar1)) begin
            ibar_pc  <= head_pc;
            ibar_pos <= !ibar0;
        end
    end

endmodule

`default_nettype wire
